// File: hw/calc_pkg.sv
`default_nettype none

package calc_pkg;

    localparam int WORD_W  = 16;                    // Operand, result and display width
    localparam int DIGIT_W = 4;                     // One decimal key

    typedef logic [WORD_W-1:0]  word_t;             // Unsigned value, wraps mod 2^16
    typedef logic [DIGIT_W-1:0] digit_t;            // Key value 0..9

    // Keypad operator codes
    typedef enum logic [1:0] {
        OP_ADD = 2'b00,                             // a + b
        OP_SUB = 2'b01,                             // a - b, wraps below zero
        OP_MUL = 2'b11                              // a * b, low half kept
    } op_t;

    // One finished expression, as queued for the dispatcher
    typedef struct packed {
        word_t operand_a;                           // First operand
        word_t operand_b;                           // Second operand
        op_t   op;                                  // Operator between them
    } calc_req_t;

endpackage

`default_nettype wire

// File: hw/operand_entry.sv
`timescale 1ns/10ps
`default_nettype none

module operand_entry (
    input  logic                clk,
    input  logic                nRST,
    input  logic                digit_strobe,       // One-cycle digit key
    input  calc_pkg::digit_t    digit,              // Valid with digit_strobe
    input  logic                op_strobe,          // One-cycle operator key
    input  calc_pkg::op_t       op_code,            // Valid with op_strobe
    input  logic                equal_strobe,       // One-cycle equal key
    input  logic                full,               // Queue cannot take a request
    output logic                push,               // Request write strobe
    output calc_pkg::calc_req_t push_req            // Request written on push
);
    import calc_pkg::*;

    typedef enum logic {
        ENTER_FIRST,                                // Building operand_a
        ENTER_SECOND                                // Building operand_b
    } state_t;

    state_t state;
    word_t  operand_a;
    word_t  operand_b;
    op_t    op_reg;                                 // Operator latched in ENTER_FIRST
    word_t  acc_sel;                                // Operand being built
    word_t  acc_next;                               // acc_sel * 10 + digit

    assign acc_sel  = (state == ENTER_FIRST) ? operand_a : operand_b;
    assign acc_next = (acc_sel << 3) + (acc_sel << 1) + word_t'(digit); // x*8 + x*2 + d

    // Equal loses to any coinciding digit or operator key
    assign push = (state == ENTER_SECOND) && equal_strobe &&
                  !digit_strobe && !op_strobe && !full;

    assign push_req.operand_a = operand_a;
    assign push_req.operand_b = operand_b;
    assign push_req.op        = op_reg;

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state     <= ENTER_FIRST;
            operand_a <= '0;
            operand_b <= '0;
            op_reg    <= OP_ADD;
        end else if (digit_strobe) begin            // Highest priority key
            if (state == ENTER_FIRST) begin
                operand_a <= acc_next;
            end else begin
                operand_b <= acc_next;
            end
        end else if (op_strobe) begin
            if (state == ENTER_FIRST) begin         // Repeat operator ignored
                op_reg <= op_code;
                state  <= ENTER_SECOND;
            end
        end else if (push) begin                    // Request leaves, start fresh
            operand_a <= '0;
            operand_b <= '0;
            state     <= ENTER_FIRST;
        end
    end

    // Equal while busy must leave the request with the user
    a_full_keeps_entry : assert property (
        @(posedge clk) disable iff (nRST)
        equal_strobe && full && !digit_strobe && !op_strobe
            |=> $stable(state) && $stable(operand_a) && $stable(operand_b)
    );

    // A push always hands back cleared operands
    a_push_restarts : assert property (
        @(posedge clk) disable iff (nRST)
        push |=> (state == ENTER_FIRST) && (operand_a == '0) && (operand_b == '0)
    );

endmodule

`default_nettype wire

// File: hw/request_queue.sv
`timescale 1ns/10ps
`default_nettype none

module request_queue #(
    parameter int QUEUE_DEPTH = 4                   // Entries, two or more
) (
    input  logic                clk,
    input  logic                nRST,
    input  logic                push,               // Write push_req
    input  calc_pkg::calc_req_t push_req,
    input  logic                pop,                // Drop head entry
    output calc_pkg::calc_req_t head_req,           // Oldest entry, valid when !empty
    output logic                full,
    output logic                empty
);
    import calc_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;                // Slot index
    typedef logic [CNT_W-1:0] cnt_t;                // Occupancy 0..QUEUE_DEPTH

    calc_req_t mem [QUEUE_DEPTH];                   // Request storage
    ptr_t      rd_ptr;
    ptr_t      wr_ptr;
    cnt_t      count;
    logic      do_push;
    logic      do_pop;

    // Wraps at QUEUE_DEPTH, so depths off a power of two work too
    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr_t'(ptr + 1'b1);
    endfunction

    assign full     = (count == cnt_t'(QUEUE_DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;                // Overflow dropped
    assign do_pop   = pop && !empty;                // Underflow dropped
    assign head_req = mem[rd_ptr];                  // Shown ahead of pop

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end                                     // Both at once keeps count
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_req;
    end

    a_no_overflow : assert property (
        @(posedge clk) disable iff (nRST) push |-> !full
    );

    a_no_underflow : assert property (
        @(posedge clk) disable iff (nRST) pop |-> !empty
    );

endmodule

`default_nettype wire

// File: hw/shift_add_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module shift_add_multiplier (
    input  logic            clk,
    input  logic            nRST,
    input  logic            start,                  // Sampled only when idle
    input  calc_pkg::word_t multiplicand,
    input  calc_pkg::word_t multiplier,
    output logic            done,                   // One-cycle result strobe
    output calc_pkg::word_t product                 // Low half, valid with done
);
    import calc_pkg::*;

    localparam int STEP_W = $clog2(WORD_W);

    word_t             acc;                         // Running partial product
    word_t             mcand_sh;                    // Multiplicand, shifted left each step
    word_t             mplier_sh;                   // Multiplier, next bit at [0]
    logic [STEP_W-1:0] step_cnt;                    // Bits already consumed
    logic              busy;
    logic              load;
    word_t             acc_step;                    // acc after this cycle's bit

    assign load     = start && !busy;
    assign acc_step = mplier_sh[0] ? acc + mcand_sh : acc;
    assign product  = acc;

    // Bit 0 is folded into the load, so 15 busy cycles finish the job
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == STEP_W'(WORD_W - 1)) begin  // Last bit consumed
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (start) begin
                busy     <= 1'b1;
                step_cnt <= STEP_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc       <= multiplier[0] ? multiplicand : '0;
            mcand_sh  <= multiplicand << 1;
            mplier_sh <= multiplier >> 1;
        end else if (busy) begin
            acc       <= acc_step;                  // Carries above bit 15 drop
            mcand_sh  <= mcand_sh << 1;
            mplier_sh <= mplier_sh >> 1;
        end
    end

    a_done_single : assert property (
        @(posedge clk) disable iff (nRST) done |=> !done
    );

    // Fixed latency the dispatcher relies on
    a_done_latency : assert property (
        @(posedge clk) disable iff (nRST) load |-> ##16 done
    );

endmodule

`default_nettype wire

// File: hw/calc_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module calc_dispatch (
    input  logic                clk,
    input  logic                nRST,
    input  logic                empty,              // Queue has nothing pending
    input  calc_pkg::calc_req_t head_req,           // Oldest request
    output logic                pop,                // Take head_req
    output logic                mult_start,         // Multiplier launch
    output calc_pkg::word_t     mult_a,
    output calc_pkg::word_t     mult_b,
    input  logic                mult_done,
    input  calc_pkg::word_t     mult_product,
    output logic                complete,           // One pulse per result
    output calc_pkg::word_t     display_output      // Last result, held
);
    import calc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,                                       // Waiting for a request
        EXECUTE,                                    // Add/sub now, or launch multiply
        WAIT_MULT,                                  // Multiplier running
        SHOW                                        // Result on display, complete high
    } state_t;

    state_t    state;
    calc_req_t req;                                 // Request being worked on
    word_t     alu_result;

    assign pop        = (state == IDLE) && !empty;
    assign mult_start = (state == EXECUTE) && (req.op == OP_MUL);
    assign mult_a     = req.operand_a;
    assign mult_b     = req.operand_b;

    always_comb begin
        case (req.op)
            OP_SUB:  alu_result = req.operand_a - req.operand_b; // Wraps below zero
            default: alu_result = req.operand_a + req.operand_b; // Unused code adds
        endcase
    end

    always_ff @(posedge clk) begin
        if (pop) req <= head_req;                   // Latch with the pop
    end

    // Display and complete load together on the edge into SHOW
    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state          <= IDLE;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            complete <= 1'b0;
            case (state)
                IDLE: begin
                    if (!empty) state <= EXECUTE;
                end
                EXECUTE: begin
                    if (req.op == OP_MUL) begin
                        state <= WAIT_MULT;         // mult_start high this cycle
                    end else begin
                        display_output <= alu_result;
                        complete       <= 1'b1;
                        state          <= SHOW;
                    end
                end
                WAIT_MULT: begin
                    if (mult_done) begin
                        display_output <= mult_product;
                        complete       <= 1'b1;
                        state          <= SHOW;
                    end
                end
                default: state <= IDLE;             // SHOW lasts one cycle
            endcase
        end
    end

    a_complete_pulse : assert property (
        @(posedge clk) disable iff (nRST) complete |=> !complete
    );

endmodule

`default_nettype wire

// File: hw/calc_top.sv
`timescale 1ns/10ps
`default_nettype none

module calc_top #(
    parameter int QUEUE_DEPTH = 4                   // Pending requests held
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             digit_strobe,
    input  calc_pkg::digit_t digit,
    input  logic             op_strobe,
    input  calc_pkg::op_t    op_code,
    input  logic             equal_strobe,
    output logic             complete,
    output calc_pkg::word_t  display_output,
    output logic             busy                   // Queue full, equal ignored
);
    import calc_pkg::*;

    logic      push;
    calc_req_t push_req;
    calc_req_t head_req;
    logic      pop;
    logic      empty;
    logic      mult_start;
    word_t     mult_a;
    word_t     mult_b;
    logic      mult_done;
    word_t     mult_product;

    operand_entry entry (
        .clk          (clk),
        .nRST         (nRST),
        .digit_strobe (digit_strobe),
        .digit        (digit),
        .op_strobe    (op_strobe),
        .op_code      (op_code),
        .equal_strobe (equal_strobe),
        .full         (busy),                       // Full level doubles as busy
        .push         (push),
        .push_req     (push_req)
    );

    request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue (
        .clk      (clk),
        .nRST     (nRST),
        .push     (push),
        .push_req (push_req),
        .pop      (pop),
        .head_req (head_req),
        .full     (busy),
        .empty    (empty)
    );

    calc_dispatch dispatch (
        .clk            (clk),
        .nRST           (nRST),
        .empty          (empty),
        .head_req       (head_req),
        .pop            (pop),
        .mult_start     (mult_start),
        .mult_a         (mult_a),
        .mult_b         (mult_b),
        .mult_done      (mult_done),
        .mult_product   (mult_product),
        .complete       (complete),
        .display_output (display_output)
    );

    shift_add_multiplier mult (
        .clk          (clk),
        .nRST         (nRST),
        .start        (mult_start),
        .multiplicand (mult_a),
        .multiplier   (mult_b),
        .done         (mult_done),
        .product      (mult_product)
    );

endmodule

`default_nettype wire

// File: bench/calc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module calc_tb;
    import calc_pkg::*;

    localparam int NUM_EXPR       = 21;             // Expressions over all tests
    localparam int KEY_CYCLES     = 12;             // Worst key entry per expression
    localparam int COMPUTE_CYCLES = 20;             // Dispatch plus multiplier
    localparam int MARGIN_CYCLES  = 100;            // Reset, idle waits
    localparam int TIMEOUT_CYCLES = NUM_EXPR * (KEY_CYCLES + COMPUTE_CYCLES) + MARGIN_CYCLES;

    logic   clk;
    logic   nRST;
    logic   digit_strobe;
    digit_t digit;
    logic   op_strobe;
    op_t    op_code;
    logic   equal_strobe;
    logic   complete;
    word_t  display_output;
    logic   busy;

    word_t  exp_q[$];                               // Results still owed, in order
    word_t  exp_val;
    string  test_name;
    integer seed;
    int     cycle_count;
    logic   busy_seen;                              // An equal key was refused

    calc_top #(.QUEUE_DEPTH(4)) dut (
        .clk            (clk),
        .nRST           (nRST),
        .digit_strobe   (digit_strobe),
        .digit          (digit),
        .op_strobe      (op_strobe),
        .op_code        (op_code),
        .equal_strobe   (equal_strobe),
        .complete       (complete),
        .display_output (display_output),
        .busy           (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                      // 10 ns period
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            $display("sim failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("sim failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Decimal operands and wrap rules, all mod 65536
    function automatic word_t model_result(input int unsigned a, input op_t op,
                                           input int unsigned b);
        longint unsigned am;
        longint unsigned bm;
        am = a % 65536;
        bm = b % 65536;
        case (op)
            OP_SUB:  return word_t'((am + 65536 - bm) % 65536);
            OP_MUL:  return word_t'((am * bm) % 65536);  // Low half of product
            default: return word_t'((am + bm) % 65536);
        endcase
    endfunction

    // All key tasks start and end 1 ns after a rising edge
    task automatic press_digit(input int unsigned d);
        digit_strobe = 1'b1;
        digit        = digit_t'(d);
        @(posedge clk);
        #1 digit_strobe = 1'b0;
    endtask

    task automatic press_op(input op_t op);
        op_strobe = 1'b1;
        op_code   = op;
        @(posedge clk);
        #1 op_strobe = 1'b0;
    endtask

    task automatic press_equal();
        equal_strobe = 1'b1;
        @(posedge clk);
        #1 equal_strobe = 1'b0;
    endtask

    task automatic enter_number(input int unsigned value);
        int unsigned digits[$];
        int unsigned v;
        v = value;
        if (v == 0) digits.push_back(0);
        while (v > 0) begin
            digits.push_front(v % 10);              // Most significant first
            v = v / 10;
        end
        foreach (digits[i]) press_digit(digits[i]);
    endtask

    // busy here is the level the DUT samples at the next edge
    task automatic press_equal_until_taken();
        logic taken;
        do begin
            taken = !busy;
            if (!taken) busy_seen = 1'b1;
            press_equal();
        end while (!taken);
    endtask

    task automatic run_expr(input int unsigned a, input op_t op, input int unsigned b);
        exp_q.push_back(model_result(a, op, b));
        enter_number(a);
        press_op(op);
        enter_number(b);
        press_equal_until_taken();
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) @(posedge clk);
        #1;
    endtask

    task automatic random_burst(input int count);
        int unsigned a;
        int unsigned b;
        int unsigned sel;
        op_t         op;
        for (int i = 0; i < count; i++) begin
            a   = $unsigned($random(seed)) % 100;   // Short keys keep the queue filling
            b   = $unsigned($random(seed)) % 100;
            sel = $unsigned($random(seed)) % 3;
            op  = (sel == 0) ? OP_ADD : (sel == 1) ? OP_SUB : OP_MUL;
            run_expr(a, op, b);
        end
    endtask

    always @(negedge clk) begin                     // Outputs settled mid-cycle
        if (!nRST && complete) begin
            if (exp_q.size() == 0) begin
                $display("complete rose with no result expected in test %s", test_name);
                $display("sim failed");
                $fatal(1, "unexpected result");
            end else begin
                exp_val = exp_q.pop_front();
                check_word(test_name, exp_val, display_output);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no result arrived after %0d cycles in test %s",
                     cycle_count, test_name);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed         = 32'h5692773f;
        cycle_count  = 0;
        busy_seen    = 1'b0;
        test_name    = "reset";
        digit_strobe = 1'b0;
        digit        = '0;
        op_strobe    = 1'b0;
        op_code      = OP_ADD;
        equal_strobe = 1'b0;
        nRST         = 1'b1;
        repeat (4) @(posedge clk);
        #1 nRST = 1'b0;

        check_bit("reset complete", 1'b0, complete);
        check_bit("reset busy", 1'b0, busy);
        check_word("reset display", '0, display_output);

        test_name = "add";
        run_expr(120, OP_ADD, 305);
        wait_results();
        repeat (3) @(posedge clk);
        #1 check_word("add display hold", 16'd425, display_output);

        test_name = "sub wrap";
        run_expr(5, OP_SUB, 12);
        wait_results();

        test_name = "mul then add";
        run_expr(300, OP_MUL, 300);                 // 90000 truncates to 24464
        run_expr(17, OP_ADD, 4);
        wait_results();

        test_name = "operand wrap";
        run_expr(99999, OP_ADD, 0);
        wait_results();

        test_name = "equal in first operand";
        exp_q.push_back(model_result(7, OP_ADD, 8));
        enter_number(7);
        press_equal();                              // Ignored, 7 kept
        press_op(OP_ADD);
        enter_number(8);
        press_equal_until_taken();
        wait_results();

        test_name = "second operator";
        exp_q.push_back(model_result(6, OP_MUL, 7));
        enter_number(6);
        press_op(OP_MUL);
        press_op(OP_ADD);                           // Ignored in second operand
        enter_number(7);
        press_equal_until_taken();
        wait_results();

        test_name = "queue full";
        busy_seen = 1'b0;
        for (int k = 0; k < 6; k++) begin
            run_expr(9 - k, OP_MUL, 9);             // Four keys each, multiplier far slower
        end
        wait_results();
        check_bit("queue full busy seen", 1'b1, busy_seen);

        test_name = "random burst";
        random_burst(8);
        wait_results();
        check_bit("burst complete idle", 1'b0, complete);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/calc_pkg.sv
hw/operand_entry.sv
hw/request_queue.sv
hw/shift_add_multiplier.sv
hw/calc_dispatch.sv
hw/calc_top.sv
bench/calc_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = calc_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
